/* src/tpg_config.svh */
`ifndef TPG_CONFIG_SVH
`define TPG_CONFIG_SVH

// --------------------
// datapath widths
// --------------------
`define TPG_CNT_W       12  // raster counters and geometry ports
`define TPG_CH_W        8   // one color channel
`define TPG_MODE_W      3   // pattern select

// --------------------
// pipeline and pattern shape
// --------------------
`define TPG_PIPE_N      5   // raster counter to output pins
`define TPG_GRID_LOG2   5   // grid pitch of 32
`define TPG_BAR_LOG2    3   // eight color bars

// --------------------
// 1280x720 default geometry
// --------------------
`define TPG_H_TOTAL_720P    1650
`define TPG_H_SYNC_720P     40
`define TPG_H_BPORCH_720P   220
`define TPG_H_RES_720P      1280
`define TPG_V_TOTAL_720P    750
`define TPG_V_SYNC_720P     5
`define TPG_V_BPORCH_720P   20
`define TPG_V_RES_720P      720

`endif

/* src/tpg_pkg.sv */
`default_nettype none
`include "tpg_config.svh"

package tpg_pkg;

    // channel order matches the packed word {b, g, r}
    typedef struct packed {
        logic [`TPG_CH_W-1:0] b;  // top byte
        logic [`TPG_CH_W-1:0] g;
        logic [`TPG_CH_W-1:0] r;  // low byte
    } rgb_t;

    // one pixel, seen either as channels or as a flat word
    typedef union packed {
        rgb_t                   ch;
        logic [3*`TPG_CH_W-1:0] word;
    } pixel_u;

    typedef enum logic [`TPG_MODE_W-1:0] {
        MODE_BAR    = 3'd0,  // eight color bars
        MODE_GRID   = 3'd1,  // red net grid
        MODE_GRAY   = 3'd2,  // horizontal gray ramp
        MODE_SINGLE = 3'd3   // color from input ports
    } mode_e;

    // --------------------
    // named colors, word is {b, g, r}
    localparam pixel_u WHITE   = 24'hff_ff_ff;
    localparam pixel_u YELLOW  = 24'h00_ff_ff;
    localparam pixel_u CYAN    = 24'hff_ff_00;
    localparam pixel_u GREEN   = 24'h00_ff_00;
    localparam pixel_u MAGENTA = 24'hff_00_ff;
    localparam pixel_u RED     = 24'h00_00_ff;
    localparam pixel_u BLUE    = 24'hff_00_00;
    localparam pixel_u BLACK   = 24'h00_00_00;

endpackage

`default_nettype wire

/* src/tpg_timing_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tpg_timing_decode (
    input  wire                   I_pxl_clk,
    input  wire                   I_rst_n,
    input  wire  [`TPG_CNT_W-1:0] I_h_total,   // clocks per line
    input  wire  [`TPG_CNT_W-1:0] I_h_sync,    // hs pulse width
    input  wire  [`TPG_CNT_W-1:0] I_h_bporch,  // sync end to first pixel
    input  wire  [`TPG_CNT_W-1:0] I_h_res,     // active pixels per line
    input  wire  [`TPG_CNT_W-1:0] I_v_total,   // lines per frame
    input  wire  [`TPG_CNT_W-1:0] I_v_sync,
    input  wire  [`TPG_CNT_W-1:0] I_v_bporch,
    input  wire  [`TPG_CNT_W-1:0] I_v_res,
    output logic                  act_de,      // stage 1
    output logic                  act_de_d,    // stage 2
    output logic [`TPG_CNT_W-1:0] act_x,       // stage 2 column
    output logic [`TPG_CNT_W-1:0] act_y,       // stage 2 row
    output logic                  sync_hs,     // stage 4, active low
    output logic                  sync_vs      // stage 4, active low
);

    localparam int SYNC_N = `TPG_PIPE_N - 1;  // last stage sits in the result block

    logic [`TPG_CNT_W-1:0] h_cnt;
    logic [`TPG_CNT_W-1:0] v_cnt;
    logic                  h_last;
    logic                  v_last;
    logic [`TPG_CNT_W-1:0] h_act_start;
    logic [`TPG_CNT_W-1:0] h_act_end;
    logic [`TPG_CNT_W-1:0] v_act_start;
    logic [`TPG_CNT_W-1:0] v_act_end;
    logic                  de_w;
    logic                  hs_w;
    logic                  vs_w;
    logic [1:0]            de_dn;
    logic [SYNC_N-1:0]     hs_dn;
    logic [SYNC_N-1:0]     vs_dn;
    logic                  de_rise;
    logic                  de_fall;
    logic                  vs_rise;

    // --------------------
    // free-running raster counters
    // --------------------
    assign h_last = (h_cnt >= I_h_total - 1'b1);
    assign v_last = (v_cnt >= I_v_total - 1'b1);

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            v_cnt <= '0;
        end else if (h_last) begin
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // step once per line
        end
    end

    // --------------------
    // raw de and syncs, stage 0
    // --------------------
    assign h_act_start = I_h_sync + I_h_bporch;
    assign h_act_end   = h_act_start + I_h_res;  // one past last column
    assign v_act_start = I_v_sync + I_v_bporch;
    assign v_act_end   = v_act_start + I_v_res;

    assign de_w = (h_cnt >= h_act_start) && (h_cnt < h_act_end) &&
                  (v_cnt >= v_act_start) && (v_cnt < v_act_end);
    assign hs_w = !(h_cnt < I_h_sync);  // low during the pulse
    assign vs_w = !(v_cnt < I_v_sync);

    // delay line, bit n is stage n+1
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            de_dn <= '0;
            hs_dn <= '1;  // syncs idle high
            vs_dn <= '1;
        end else begin
            de_dn <= {de_dn[0], de_w};
            hs_dn <= {hs_dn[SYNC_N-2:0], hs_w};
            vs_dn <= {vs_dn[SYNC_N-2:0], vs_w};
        end
    end

    assign act_de   = de_dn[0];
    assign act_de_d = de_dn[1];
    assign sync_hs  = hs_dn[SYNC_N-1];
    assign sync_vs  = vs_dn[SYNC_N-1];

    // --------------------
    // active position, aligned with act_de_d
    // --------------------
    assign de_rise = de_dn[0] & ~de_dn[1];
    assign de_fall = de_dn[1] & ~de_dn[0];
    assign vs_rise = vs_dn[0] & ~vs_dn[1];  // end of vs pulse

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            act_x <= '0;
        end else if (de_rise) begin
            act_x <= '0;  // first pixel shows 0 one clock later
        end else if (act_de_d) begin
            act_x <= act_x + 1'b1;
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            act_y <= '0;
        end else if (vs_rise) begin
            act_y <= '0;
        end else if (de_fall) begin
            act_y <= act_y + 1'b1;  // after the last pixel of a line
        end
    end

endmodule

`default_nettype wire

/* src/tpg_pattern_execute.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tpg_pattern_execute (
    input  wire                   I_pxl_clk,
    input  wire                   I_rst_n,
    input  wire  [`TPG_CNT_W-1:0] I_h_res,
    input  wire  [`TPG_CNT_W-1:0] I_v_res,
    input  wire                   act_de,    // stage 1
    input  wire                   act_de_d,  // stage 2
    input  wire  [`TPG_CNT_W-1:0] act_x,     // stage 2
    input  wire  [`TPG_CNT_W-1:0] act_y,     // stage 2
    output tpg_pkg::pixel_u       bar_pix,   // stage 4
    output tpg_pkg::pixel_u       grid_pix,  // stage 4
    output tpg_pkg::pixel_u       gray_pix,  // stage 4
    output logic                  pat_de     // stage 4
);

    logic [`TPG_CNT_W-1:0]   bar_w;     // h_res / 8
    logic [`TPG_CNT_W-1:0]   bar_edge;  // first column of the next bar
    logic [`TPG_BAR_LOG2-1:0] bar_idx;  // stage 3
    logic                    de_s3;
    logic                    h_hit;     // stage 3
    logic                    v_hit;     // stage 3
    logic [`TPG_CH_W-1:0]    gray_s3;

    // shared stage 3 and 4 valid
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            de_s3  <= 1'b0;
            pat_de <= 1'b0;
        end else begin
            de_s3  <= act_de_d;
            pat_de <= de_s3;
        end
    end

    // --------------------
    // color bar
    // --------------------
    assign bar_w = I_h_res >> `TPG_BAR_LOG2;

    // preload between lines, step as each bar boundary passes
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            bar_edge <= '0;
        end else if (!act_de) begin
            bar_edge <= bar_w;
        end else if (act_de_d && (act_x == bar_edge)) begin
            bar_edge <= bar_edge + bar_w;
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            bar_idx <= '0;
        end else if (!act_de_d) begin
            bar_idx <= '0;  // restart each line
        end else if (act_x == bar_edge) begin
            bar_idx <= bar_idx + 1'b1;
        end
    end

    // registered lookup, order fixed by the bar pattern
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            bar_pix <= tpg_pkg::BLACK;
        end else if (!de_s3) begin
            bar_pix <= tpg_pkg::BLACK;
        end else begin
            case (bar_idx)
                3'd0: bar_pix <= tpg_pkg::WHITE;
                3'd1: bar_pix <= tpg_pkg::YELLOW;
                3'd2: bar_pix <= tpg_pkg::CYAN;
                3'd3: bar_pix <= tpg_pkg::GREEN;
                3'd4: bar_pix <= tpg_pkg::MAGENTA;
                3'd5: bar_pix <= tpg_pkg::RED;
                3'd6: bar_pix <= tpg_pkg::BLACK;
                3'd7: bar_pix <= tpg_pkg::BLUE;
            endcase
        end
    end

    // --------------------
    // net grid
    // --------------------
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            h_hit <= 1'b0;
            v_hit <= 1'b0;
        end else begin
            // every 32nd line plus the closing edge of the raster
            h_hit <= (act_x[`TPG_GRID_LOG2-1:0] == '0) || (act_x == I_h_res - 1'b1);
            v_hit <= (act_y[`TPG_GRID_LOG2-1:0] == '0) || (act_y == I_v_res - 1'b1);
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            grid_pix <= tpg_pkg::BLACK;
        end else if (de_s3 && (h_hit || v_hit)) begin
            grid_pix <= tpg_pkg::RED;
        end else begin
            grid_pix <= tpg_pkg::BLACK;
        end
    end

    // --------------------
    // gray ramp
    // --------------------
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            gray_s3 <= '0;
        end else begin
            gray_s3 <= act_x[`TPG_CH_W-1:0];  // wraps every 256 columns
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            gray_pix <= tpg_pkg::BLACK;
        end else if (de_s3) begin
            gray_pix.word <= {3{gray_s3}};  // same level on r, g, b
        end else begin
            gray_pix <= tpg_pkg::BLACK;
        end
    end

endmodule

`default_nettype wire

/* src/tpg_pixel_result.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tpg_pixel_result (
    input  wire                   I_pxl_clk,
    input  wire                   I_rst_n,
    input  wire  [`TPG_MODE_W-1:0] I_mode,
    input  wire  [`TPG_CH_W-1:0]  I_single_r,
    input  wire  [`TPG_CH_W-1:0]  I_single_g,
    input  wire  [`TPG_CH_W-1:0]  I_single_b,
    input  wire                   I_hs_pol,  // 1 gives a positive hs pulse
    input  wire                   I_vs_pol,
    input  wire tpg_pkg::pixel_u  bar_pix,   // stage 4 candidates
    input  wire tpg_pkg::pixel_u  grid_pix,
    input  wire tpg_pkg::pixel_u  gray_pix,
    input  wire                   pat_de,
    input  wire                   sync_hs,   // raw, active low
    input  wire                   sync_vs,
    output logic                  O_de,      // stage 5 from here on
    output logic                  O_hs,
    output logic                  O_vs,
    output logic [`TPG_CH_W-1:0]  O_data_r,
    output logic [`TPG_CH_W-1:0]  O_data_g,
    output logic [`TPG_CH_W-1:0]  O_data_b,
    output logic [15:0]           O_rgb565   // {r5, g6, b5}
);

    tpg_pkg::pixel_u single_pix;
    tpg_pkg::pixel_u pix_sel;
    tpg_pkg::pixel_u pix_q;
    logic            de_q;
    logic            hs_q;
    logic            vs_q;

    assign single_pix.ch = '{b: I_single_b, g: I_single_g, r: I_single_r};

    // --------------------
    // pattern select, undefined modes go blue
    always_comb begin
        case (tpg_pkg::mode_e'(I_mode))
            tpg_pkg::MODE_BAR:    pix_sel = bar_pix;
            tpg_pkg::MODE_GRID:   pix_sel = grid_pix;
            tpg_pkg::MODE_GRAY:   pix_sel = gray_pix;
            tpg_pkg::MODE_SINGLE: pix_sel = single_pix;
            default:              pix_sel = tpg_pkg::BLUE;
        endcase
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            pix_q <= tpg_pkg::BLACK;
            de_q  <= 1'b0;
            hs_q  <= 1'b1;  // raw idle level
            vs_q  <= 1'b1;
        end else begin
            pix_q <= pix_sel;
            de_q  <= pat_de;
            hs_q  <= sync_hs;
            vs_q  <= sync_vs;
        end
    end

    // --------------------
    // output mapping
    assign O_de = de_q;
    assign O_hs = hs_q ^ I_hs_pol;  // flip after the register, idle is ~pol
    assign O_vs = vs_q ^ I_vs_pol;

    assign O_data_r = pix_q.ch.r;
    assign O_data_g = pix_q.ch.g;
    assign O_data_b = pix_q.ch.b;

    // keep the top bits of each channel
    assign O_rgb565 = {pix_q.ch.r[`TPG_CH_W-1 -: 5],
                       pix_q.ch.g[`TPG_CH_W-1 -: 6],
                       pix_q.ch.b[`TPG_CH_W-1 -: 5]};

endmodule

`default_nettype wire

/* src/tpg_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tpg_top (
    input  wire                    I_pxl_clk,
    input  wire                    I_rst_n,
    input  wire  [`TPG_MODE_W-1:0] I_mode,      // pattern select
    input  wire  [`TPG_CH_W-1:0]   I_single_r,  // mode 3 color
    input  wire  [`TPG_CH_W-1:0]   I_single_g,
    input  wire  [`TPG_CH_W-1:0]   I_single_b,
    input  wire  [`TPG_CNT_W-1:0]  I_h_total,
    input  wire  [`TPG_CNT_W-1:0]  I_h_sync,
    input  wire  [`TPG_CNT_W-1:0]  I_h_bporch,
    input  wire  [`TPG_CNT_W-1:0]  I_h_res,
    input  wire  [`TPG_CNT_W-1:0]  I_v_total,
    input  wire  [`TPG_CNT_W-1:0]  I_v_sync,
    input  wire  [`TPG_CNT_W-1:0]  I_v_bporch,
    input  wire  [`TPG_CNT_W-1:0]  I_v_res,
    input  wire                    I_hs_pol,    // 1 for positive pulse
    input  wire                    I_vs_pol,
    output wire                    O_de,
    output wire                    O_hs,
    output wire                    O_vs,
    output wire  [`TPG_CH_W-1:0]   O_data_r,
    output wire  [`TPG_CH_W-1:0]   O_data_g,
    output wire  [`TPG_CH_W-1:0]   O_data_b,
    output wire  [15:0]            O_rgb565
);

    // --------------------
    // stage links
    wire                   act_de;
    wire                   act_de_d;
    wire [`TPG_CNT_W-1:0]  act_x;
    wire [`TPG_CNT_W-1:0]  act_y;
    wire                   sync_hs;
    wire                   sync_vs;
    wire tpg_pkg::pixel_u  bar_pix;
    wire tpg_pkg::pixel_u  grid_pix;
    wire tpg_pkg::pixel_u  gray_pix;
    wire                   pat_de;

    tpg_timing_decode i_decode (
        .I_pxl_clk  (I_pxl_clk),
        .I_rst_n    (I_rst_n),
        .I_h_total  (I_h_total),
        .I_h_sync   (I_h_sync),
        .I_h_bporch (I_h_bporch),
        .I_h_res    (I_h_res),
        .I_v_total  (I_v_total),
        .I_v_sync   (I_v_sync),
        .I_v_bporch (I_v_bporch),
        .I_v_res    (I_v_res),
        .act_de     (act_de),
        .act_de_d   (act_de_d),
        .act_x      (act_x),
        .act_y      (act_y),
        .sync_hs    (sync_hs),
        .sync_vs    (sync_vs)
    );

    tpg_pattern_execute i_execute (
        .I_pxl_clk (I_pxl_clk),
        .I_rst_n   (I_rst_n),
        .I_h_res   (I_h_res),
        .I_v_res   (I_v_res),
        .act_de    (act_de),
        .act_de_d  (act_de_d),
        .act_x     (act_x),
        .act_y     (act_y),
        .bar_pix   (bar_pix),
        .grid_pix  (grid_pix),
        .gray_pix  (gray_pix),
        .pat_de    (pat_de)
    );

    tpg_pixel_result i_result (
        .I_pxl_clk  (I_pxl_clk),
        .I_rst_n    (I_rst_n),
        .I_mode     (I_mode),
        .I_single_r (I_single_r),
        .I_single_g (I_single_g),
        .I_single_b (I_single_b),
        .I_hs_pol   (I_hs_pol),
        .I_vs_pol   (I_vs_pol),
        .bar_pix    (bar_pix),
        .grid_pix   (grid_pix),
        .gray_pix   (gray_pix),
        .pat_de     (pat_de),
        .sync_hs    (sync_hs),
        .sync_vs    (sync_vs),
        .O_de       (O_de),
        .O_hs       (O_hs),
        .O_vs       (O_vs),
        .O_data_r   (O_data_r),
        .O_data_g   (O_data_g),
        .O_data_b   (O_data_b),
        .O_rgb565   (O_rgb565)
    );

endmodule

`default_nettype wire

/* verif/tpg_assert.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tpg_assert (
    input wire                  I_pxl_clk,
    input wire                  I_rst_n,
    input wire                  I_hs_pol,
    input wire                  I_vs_pol,
    input wire                  O_de,
    input wire                  O_hs,
    input wire                  O_vs,
    input wire [`TPG_CH_W-1:0]  O_data_r,
    input wire [`TPG_CH_W-1:0]  O_data_g,
    input wire [`TPG_CH_W-1:0]  O_data_b,
    input wire [15:0]           O_rgb565
);

    // blanking covers both sync pulses
    a_de_hs : assert property (@(posedge I_pxl_clk) disable iff (!I_rst_n)
        O_de |-> (O_hs != I_hs_pol)) else $error("de high inside hs pulse");

    a_de_vs : assert property (@(posedge I_pxl_clk) disable iff (!I_rst_n)
        O_de |-> (O_vs != I_vs_pol)) else $error("de high inside vs pulse");

    a_rst_de : assert property (@(posedge I_pxl_clk)
        !I_rst_n |-> !O_de) else $error("de high during reset");

    // packed word tracks the channels
    a_565 : assert property (@(posedge I_pxl_clk) disable iff (!I_rst_n)
        O_rgb565 == {O_data_r[7:3], O_data_g[7:2], O_data_b[7:3]})
        else $error("rgb565 does not match channels");

endmodule

bind tpg_top tpg_assert i_assert (
    .I_pxl_clk (I_pxl_clk),
    .I_rst_n   (I_rst_n),
    .I_hs_pol  (I_hs_pol),
    .I_vs_pol  (I_vs_pol),
    .O_de      (O_de),
    .O_hs      (O_hs),
    .O_vs      (O_vs),
    .O_data_r  (O_data_r),
    .O_data_g  (O_data_g),
    .O_data_b  (O_data_b),
    .O_rgb565  (O_rgb565)
);

`default_nettype wire

/* verif/tb_tpg.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tpg_config.svh"

module tb_tpg;

    localparam int N_ROWS = 7;

    // one test row holds mode, geometry, polarity, single color and frame count
    typedef struct {
        int mode;
        int ht;
        int hsy;
        int hbp;
        int hr;
        int vt;
        int vsy;
        int vbp;
        int vr;
        int hpol;
        int vpol;
        int sr;
        int sg;
        int sb;
        int frames;
    } row_t;

    logic                   I_pxl_clk;
    logic                   I_rst_n;
    logic [`TPG_MODE_W-1:0] I_mode;
    logic [`TPG_CH_W-1:0]   I_single_r;
    logic [`TPG_CH_W-1:0]   I_single_g;
    logic [`TPG_CH_W-1:0]   I_single_b;
    logic [`TPG_CNT_W-1:0]  I_h_total;
    logic [`TPG_CNT_W-1:0]  I_h_sync;
    logic [`TPG_CNT_W-1:0]  I_h_bporch;
    logic [`TPG_CNT_W-1:0]  I_h_res;
    logic [`TPG_CNT_W-1:0]  I_v_total;
    logic [`TPG_CNT_W-1:0]  I_v_sync;
    logic [`TPG_CNT_W-1:0]  I_v_bporch;
    logic [`TPG_CNT_W-1:0]  I_v_res;
    logic                   I_hs_pol;
    logic                   I_vs_pol;
    wire                    O_de;
    wire                    O_hs;
    wire                    O_vs;
    wire  [`TPG_CH_W-1:0]   O_data_r;
    wire  [`TPG_CH_W-1:0]   O_data_g;
    wire  [`TPG_CH_W-1:0]   O_data_b;
    wire  [15:0]            O_rgb565;

    row_t   rows [N_ROWS];
    int     cur_row;
    int     seed;
    longint cycles;
    longint cycle_limit;
    int     checked_frames;
    bit     checking;     // set by the main loop
    bit     frame_open;   // current frame started while checking
    int     vs_starts;
    // monitor state
    bit     hs_prev;
    bit     vs_prev;
    bit     de_prev;
    bit     hs_track;
    bit     vs_track;
    bit     de_track;
    int     hs_run;
    int     vs_run;
    int     de_run;
    int     x;
    int     y;
    int     lines;

    tpg_top i_dut (.*);

    initial begin
        I_pxl_clk = 1'b0;
        forever #5 I_pxl_clk = ~I_pxl_clk;  // 10 ns period
    end

    // --------------------
    // checking helpers
    // --------------------
    task automatic expect_equal(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("ERROR: %0t ns %s expected %0d got %0d", $time, what, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // expected pixel as {r, g, b}
    function automatic logic [23:0] ref_pixel(input int i, input int px, input int py);
        int          idx;
        logic [7:0]  lvl;
        logic [23:0] pix;
        pix = 24'h0000ff;  // undefined modes give blue
        case (rows[i].mode)
            0: begin
                idx = px / (rows[i].hr / 8);
                if (idx > 7)
                    idx = 7;
                case (idx)
                    0: pix = 24'hffffff;  // white
                    1: pix = 24'hffff00;  // yellow
                    2: pix = 24'h00ffff;  // cyan
                    3: pix = 24'h00ff00;  // green
                    4: pix = 24'hff00ff;  // magenta
                    5: pix = 24'hff0000;  // red
                    6: pix = 24'h000000;  // black
                    default: pix = 24'h0000ff;
                endcase
            end
            1: begin
                if ((px % 32 == 0) || (py % 32 == 0) ||
                    (px == rows[i].hr - 1) || (py == rows[i].vr - 1)) begin
                    pix = 24'hff0000;
                end else begin
                    pix = 24'h000000;
                end
            end
            2: begin
                lvl = 8'(px % 256);
                pix = {lvl, lvl, lvl};
            end
            3: pix = {8'(rows[i].sr), 8'(rows[i].sg), 8'(rows[i].sb)};
            default: pix = 24'h0000ff;
        endcase
        return pix;
    endfunction

    task automatic check_pixel(input int px, input int py);
        logic [23:0] exp;
        exp = ref_pixel(cur_row, px, py);
        expect_equal(O_data_r, exp[23:16], "red channel");
        expect_equal(O_data_g, exp[15:8], "green channel");
        expect_equal(O_data_b, exp[7:0], "blue channel");
        expect_equal(O_rgb565, {exp[23:19], exp[15:10], exp[7:3]}, "rgb565 word");
    endtask

    // --------------------
    // output monitor sampled mid-cycle
    // --------------------
    always @(negedge I_pxl_clk) begin
        bit hs_act;
        bit vs_act;
        if (I_rst_n) begin
            hs_act = (O_hs == rows[cur_row].hpol[0]);  // pulse level
            vs_act = (O_vs == rows[cur_row].vpol[0]);
            // vs first since a new frame opens here
            if (vs_act && !vs_prev) begin
                if (checking && frame_open) begin
                    expect_equal(lines, rows[cur_row].vr, "active lines per frame");
                    checked_frames++;
                end
                frame_open = checking;
                lines      = 0;
                y          = 0;
                vs_run     = 0;
                vs_track   = frame_open;
                vs_starts++;
            end
            if (vs_act) begin
                vs_run++;
            end else if (vs_prev && vs_track && checking) begin
                expect_equal(vs_run, rows[cur_row].vsy * rows[cur_row].ht, "vs pulse width");
            end
            if (hs_act && !hs_prev) begin
                hs_run   = 0;
                hs_track = frame_open;
            end
            if (hs_act) begin
                hs_run++;
            end else if (hs_prev && hs_track && checking) begin
                expect_equal(hs_run, rows[cur_row].hsy, "hs pulse width");
            end
            if (O_de) begin
                if (!de_prev) begin
                    x        = 0;  // first column of a line
                    de_run   = 0;
                    de_track = frame_open;
                end else begin
                    x++;
                end
                de_run++;
                if (frame_open && checking)
                    check_pixel(x, y);
            end else if (de_prev) begin
                if (de_track && checking) begin
                    expect_equal(de_run, rows[cur_row].hr, "pixels per line");
                end
                lines++;
                y++;
            end
            hs_prev = hs_act;
            vs_prev = vs_act;
            de_prev = O_de;
        end
    end

    // --------------------
    // timeout
    // --------------------
    always @(posedge I_pxl_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run took more than %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic load_table();
        //            mode ht   hs  hb  hr   vt  vs vb vr  hp vp sr sg sb fr
        rows[0] = '{0, 120, 8,  12, 64,  80, 3, 5, 40, 0, 0, 0, 0, 0, 2};
        rows[1] = '{1, 120, 8,  12, 64,  80, 3, 5, 40, 1, 0, 0, 0, 0, 2};
        rows[2] = '{2, 140, 10, 20, 96,  70, 2, 4, 48, 1, 1, 0, 0, 0, 2};
        rows[3] = '{3, 120, 8,  12, 64,  80, 3, 5, 40, 0, 1, 0, 0, 0, 1};
        rows[4] = '{5, 140, 10, 20, 96,  70, 2, 4, 48, 0, 0, 0, 0, 0, 1};
        rows[5] = '{1, 140, 10, 20, 96,  70, 2, 4, 48, 1, 0, 0, 0, 0, 2};
        rows[6] = '{0, `TPG_H_TOTAL_720P, `TPG_H_SYNC_720P, `TPG_H_BPORCH_720P,
                    `TPG_H_RES_720P, `TPG_V_TOTAL_720P, `TPG_V_SYNC_720P,
                    `TPG_V_BPORCH_720P, `TPG_V_RES_720P, 1, 1, 0, 0, 0, 1};
    endtask

    task automatic drive_row(input int i);
        I_mode     = 3'(rows[i].mode);
        I_single_r = 8'(rows[i].sr);
        I_single_g = 8'(rows[i].sg);
        I_single_b = 8'(rows[i].sb);
        I_h_total  = 12'(rows[i].ht);
        I_h_sync   = 12'(rows[i].hsy);
        I_h_bporch = 12'(rows[i].hbp);
        I_h_res    = 12'(rows[i].hr);
        I_v_total  = 12'(rows[i].vt);
        I_v_sync   = 12'(rows[i].vsy);
        I_v_bporch = 12'(rows[i].vbp);
        I_v_res    = 12'(rows[i].vr);
        I_hs_pol   = rows[i].hpol[0];
        I_vs_pol   = rows[i].vpol[0];
    endtask

    initial begin
        int base;
        int total_frames;
        seed           = 32'h86e48321;
        cycles         = 0;
        cycle_limit    = 0;
        total_frames   = 0;
        checked_frames = 0;
        checking       = 1'b0;
        frame_open     = 1'b0;
        vs_starts      = 0;
        cur_row        = 0;
        I_rst_n        = 1'b0;
        load_table();
        rows[3].sr = $random(seed) & 255;  // arbitrary single color
        rows[3].sg = $random(seed) & 255;
        rows[3].sb = $random(seed) & 255;
        drive_row(0);
        for (int i = 0; i < N_ROWS; i++) begin
            cycle_limit += longint'(rows[i].frames + 2) * rows[i].ht * rows[i].vt;
            total_frames += rows[i].frames;
        end
        cycle_limit += 1000;

        repeat (4) @(posedge I_pxl_clk);
        #1 I_rst_n = 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge I_pxl_clk);
            #1;
            checking = 1'b0;
            cur_row  = i;
            drive_row(i);
            base = vs_starts;
            wait (vs_starts >= base + 1);  // settling frame begins
            @(posedge I_pxl_clk);
            #1 checking = 1'b1;
            wait (vs_starts >= base + 2 + rows[i].frames);
        end
        @(posedge I_pxl_clk);
        #1 checking = 1'b0;

        if (checked_frames == total_frames) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("the run checked %0d frames instead of %0d", checked_frames,
                     total_frames);
            $display("SIMULATION FAILED");
            $fatal(1, "run failed");
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/tpg_pkg.sv
src/tpg_timing_decode.sv
src/tpg_pattern_execute.sv
src/tpg_pixel_result.sv
src/tpg_top.sv
verif/tpg_assert.sv
verif/tb_tpg.sv

/* run_sim.sh */
#!/bin/bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tpg -f all.f \
    && ./obj_dir/Vtb_tpg 2>&1 | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "test failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "test did not complete"; exit 1; }
echo "test passed"
exit 0
